/* verilog/hello_pkg.sv */
// ----------------------------------------------------------
// Hello world shell package
// Bus widths, register map and write-phase encoding
// ----------------------------------------------------------
`default_nettype none

package hello_pkg;

  // ----------------------------------------------------------
  // Bus and register widths
  // ----------------------------------------------------------

  // Host byte address
  typedef logic [31:0] addr_t;
  // Register data word
  typedef logic [31:0] data_t;
  // Write byte strobes, one per data byte
  typedef logic [3:0]  strb_t;
  // AXI response code
  typedef logic [1:0]  resp_t;
  // Virtual LED and DIP vector
  typedef logic [15:0] led_t;

  // Write channel sequencing
  // WR_BUSY covers both the wait for data and the wait for bready
  typedef enum logic {
    WR_IDLE,
    WR_BUSY
  } wr_phase_e;

  // ----------------------------------------------------------
  // Register map
  // ----------------------------------------------------------
  localparam addr_t HELLO_REG_ADDR = 32'h0000_0500;
  localparam addr_t VLED_REG_ADDR  = 32'h0000_0504;

  // Returned for any address outside the map
  localparam data_t UNIMPL_REG_VALUE = 32'hdead_dead;

  // Only response ever given
  localparam resp_t RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

/* verilog/reg_access_if.sv */
// ----------------------------------------------------------
// Register access link between the write, register and read stages
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface reg_access_if;

  // Write strobe, valid for exactly one cycle per accepted beat
  logic                wr_en;
  // Latched write address and data word for that beat
  hello_pkg::addr_t    wr_addr;
  hello_pkg::data_t    wr_data;

  // Read-back values from the register stage
  // Hello value already byte-reversed
  hello_pkg::data_t    hello_rdata;
  // LED shadow of the hello low half
  hello_pkg::led_t     vled_rdata;

  // Write channel side
  modport wr_src (
    output wr_en,
    output wr_addr,
    output wr_data
  );

  // Register stage
  modport regs (
    input  wr_en,
    input  wr_addr,
    input  wr_data,
    output hello_rdata,
    output vled_rdata
  );

  // Read channel side
  modport rd_sink (
    input  hello_rdata,
    input  vled_rdata
  );

endinterface

`default_nettype wire

/* verilog/axil_wr_ctrl.sv */
// ----------------------------------------------------------
// AXI-Lite write channel: address accept, data beat, response
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module axil_wr_ctrl (
  input  wire                 clk_main_a0,
  input  wire                 rst_main_n_sync,
  // Write address channel
  input  wire                 awvalid,
  input  hello_pkg::addr_t    awaddr,
  output logic                awready,
  // Write data channel
  input  wire                 wvalid,
  input  hello_pkg::data_t    wdata,
  output logic                wready,
  // Write response channel
  output logic                bvalid,
  output hello_pkg::resp_t    bresp,
  input  wire                 bready,
  // Link to register stage
  reg_access_if.wr_src        acc
);

  import hello_pkg::*;

  wr_phase_e wr_phase;
  addr_t     wr_addr_q;

  // ----------------------------------------------------------
  // Address phase
  // ----------------------------------------------------------

  // Open for a new address only when no transaction is in flight
  assign awready = (wr_phase == WR_IDLE);

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      wr_phase  <= WR_IDLE;
      wr_addr_q <= '0;
    end else begin
      case (wr_phase)
        WR_IDLE: begin
          // Take the address and wait for the data beat
          if (awvalid) begin
            wr_phase  <= WR_BUSY;
            wr_addr_q <= awaddr;
          end
        end
        WR_BUSY: begin
          // Done once the host takes the response
          if (bvalid && bready)
            wr_phase <= WR_IDLE;
        end
        default: wr_phase <= WR_IDLE;
      endcase
    end
  end

  // ----------------------------------------------------------
  // Data phase
  // ----------------------------------------------------------

  // Single beat per address; no second beat while response pending
  assign wready = (wr_phase == WR_BUSY) && wvalid && !bvalid;

  // Register stage writes at the same edge as the data handshake
  assign acc.wr_en   = wready;
  assign acc.wr_addr = wr_addr_q;
  assign acc.wr_data = wdata;

  // ----------------------------------------------------------
  // Response phase
  // ----------------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync)
      bvalid <= 1'b0;
    else if (bvalid && bready)
      bvalid <= 1'b0;
    else if (wready)
      bvalid <= 1'b1;
  end

  // Strobes are not decoded, so every write lands as a full word
  assign bresp = RESP_OKAY;

endmodule

`default_nettype wire

/* verilog/hello_regs.sv */
// ----------------------------------------------------------
// Hello register, LED shadow and DIP-masked LED output
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module hello_regs (
  input  wire                 clk_main_a0,
  input  wire                 rst_main_n_sync,
  // Virtual DIP switches, asynchronous to clk_main_a0
  input  hello_pkg::led_t     vdip,
  // Virtual LEDs
  output hello_pkg::led_t     vled,
  // Link from write stage and to read stage
  reg_access_if.regs          acc
);

  import hello_pkg::*;

  data_t hello_q;
  led_t  vled_q;
  led_t  vdip_q;
  led_t  vdip_q2;
  led_t  vled_masked;
  logic  hello_wr;

  // ----------------------------------------------------------
  // Hello register
  // ----------------------------------------------------------

  // Decode for the one write-enabled location
  assign hello_wr = acc.wr_en && (acc.wr_addr == HELLO_REG_ADDR);

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync)
      hello_q <= '0;
    else if (hello_wr)
      hello_q <= acc.wr_data;
  end

  // Read-back is byte-reversed, byte 0 moves to the top
  assign acc.hello_rdata = {hello_q[7:0],
                            hello_q[15:8],
                            hello_q[23:16],
                            hello_q[31:24]};

  // ----------------------------------------------------------
  // LED shadow
  // ----------------------------------------------------------

  // Tracks hello low half one cycle late
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync)
      vled_q <= '0;
    else
      vled_q <= hello_q[15:0];
  end

  assign acc.vled_rdata = vled_q;

  // ----------------------------------------------------------
  // DIP synchronizer and LED output
  // ----------------------------------------------------------

  // Two-flop resync of the switch inputs
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vdip_q  <= '0;
      vdip_q2 <= '0;
    end else begin
      vdip_q  <= vdip;
      vdip_q2 <= vdip_q;
    end
  end

  // LED lit only where its switch is on
  assign vled_masked = vled_q & vdip_q2;

  // Output flop, so vled settles within four cycles of a change
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync)
      vled <= '0;
    else
      vled <= vled_masked;
  end

endmodule

`default_nettype wire

/* verilog/axil_rd_ctrl.sv */
// ----------------------------------------------------------
// AXI-Lite read channel: request capture, decode, response
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module axil_rd_ctrl (
  input  wire                 clk_main_a0,
  input  wire                 rst_main_n_sync,
  // Read address channel
  input  wire                 arvalid,
  input  hello_pkg::addr_t    araddr,
  output logic                arready,
  // Read data channel
  output logic                rvalid,
  output hello_pkg::data_t    rdata,
  output hello_pkg::resp_t    rresp,
  input  wire                 rready,
  // Read-back values from register stage
  reg_access_if.rd_sink       acc
);

  import hello_pkg::*;

  logic  arvalid_q;
  addr_t araddr_q;
  data_t rdata_dec;

  // ----------------------------------------------------------
  // Request capture
  // ----------------------------------------------------------

  // Request sampled every cycle; address held between requests
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      arvalid_q <= 1'b0;
      araddr_q  <= '0;
    end else begin
      arvalid_q <= arvalid;
      if (arvalid)
        araddr_q <= araddr;
    end
  end

  // Busy from capture until the host takes the response
  assign arready = !arvalid_q && !rvalid;

  // ----------------------------------------------------------
  // Address decode
  // ----------------------------------------------------------
  always_comb begin
    case (araddr_q)
      HELLO_REG_ADDR: rdata_dec = acc.hello_rdata;
      // Shadow is 16 bits wide, upper half reads zero
      VLED_REG_ADDR:  rdata_dec = {16'h0000, acc.vled_rdata};
      default:        rdata_dec = UNIMPL_REG_VALUE;
    endcase
  end

  // ----------------------------------------------------------
  // Read response
  // ----------------------------------------------------------

  // Response cleared on acceptance, loaded one cycle after capture
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rvalid <= 1'b0;
      rdata  <= '0;
      rresp  <= RESP_OKAY;
    end else if (rvalid && rready) begin
      rvalid <= 1'b0;
      rdata  <= '0;
      rresp  <= RESP_OKAY;
    end else if (arvalid_q) begin
      rvalid <= 1'b1;
      rdata  <= rdata_dec;
      rresp  <= RESP_OKAY;
    end
  end

endmodule

`default_nettype wire

/* verilog/cl_hello_world.sv */
// ----------------------------------------------------------
// Hello world shell top: host AXI-Lite slave and virtual LEDs
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cl_hello_world (
  input  wire                 clk_main_a0,
  // Arrives already synchronized to clk_main_a0
  input  wire                 rst_main_n_sync,

  // Host write address channel
  input  wire                 awvalid,
  input  hello_pkg::addr_t    awaddr,
  output logic                awready,

  // Host write data channel
  input  wire                 wvalid,
  input  hello_pkg::data_t    wdata,
  // Byte strobes are not decoded, writes are always full-word
  input  hello_pkg::strb_t    wstrb,
  output logic                wready,

  // Host write response channel
  output logic                bvalid,
  output hello_pkg::resp_t    bresp,
  input  wire                 bready,

  // Host read address channel
  input  wire                 arvalid,
  input  hello_pkg::addr_t    araddr,
  output logic                arready,

  // Host read data channel
  output logic                rvalid,
  output hello_pkg::data_t    rdata,
  output hello_pkg::resp_t    rresp,
  input  wire                 rready,

  // Virtual DIP switches in, masked LEDs out
  input  hello_pkg::led_t     vdip,
  output hello_pkg::led_t     vled
);

  import hello_pkg::*;

  // Shared link between the three stages
  reg_access_if acc ();

  // ----------------------------------------------------------
  // Write channel stage
  // ----------------------------------------------------------
  axil_wr_ctrl u_wr_ctrl (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (awvalid),
    .awaddr          (awaddr),
    .awready         (awready),
    .wvalid          (wvalid),
    .wdata           (wdata),
    .wready          (wready),
    .bvalid          (bvalid),
    .bresp           (bresp),
    .bready          (bready),
    .acc             (acc)
  );

  // ----------------------------------------------------------
  // Register stage
  // ----------------------------------------------------------
  hello_regs u_regs (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .vdip            (vdip),
    .vled            (vled),
    .acc             (acc)
  );

  // ----------------------------------------------------------
  // Read channel stage
  // ----------------------------------------------------------
  axil_rd_ctrl u_rd_ctrl (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .arvalid         (arvalid),
    .araddr          (araddr),
    .arready         (arready),
    .rvalid          (rvalid),
    .rdata           (rdata),
    .rresp           (rresp),
    .rready          (rready),
    .acc             (acc)
  );

endmodule

`default_nettype wire

/* tb/cl_hello_world_tb.sv */
// ----------------------------------------------------------
// Hello world shell testbench replaying the stimulus file
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cl_hello_world_tb;

  import hello_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 16;
  localparam int HS_TIMEOUT   = 20;
  localparam int LED_TIMEOUT  = 8;

  logic  clk_main_a0;
  logic  rst_main_n_sync;
  // Write channels
  logic  awvalid;
  logic  awready;
  logic  wvalid;
  logic  wready;
  logic  bvalid;
  logic  bready;
  // Read channels
  logic  arvalid;
  logic  arready;
  logic  rvalid;
  logic  rready;
  addr_t awaddr;
  addr_t araddr;
  data_t wdata;
  data_t rdata;
  strb_t wstrb;
  resp_t bresp;
  resp_t rresp;
  // Virtual switches and LEDs
  led_t  vdip;
  led_t  vled;

  integer seed;
  // Reference copy of the hello register
  data_t  hello_model;

  cl_hello_world uut (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (awvalid),
    .awaddr          (awaddr),
    .awready         (awready),
    .wvalid          (wvalid),
    .wdata           (wdata),
    .wstrb           (wstrb),
    .wready          (wready),
    .bvalid          (bvalid),
    .bresp           (bresp),
    .bready          (bready),
    .arvalid         (arvalid),
    .araddr          (araddr),
    .arready         (arready),
    .rvalid          (rvalid),
    .rdata           (rdata),
    .rresp           (rresp),
    .rready          (rready),
    .vdip            (vdip),
    .vled            (vled)
  );

  // Free-running clock
  initial begin
    clk_main_a0 = 1'b0;
    forever #(CLK_PERIOD / 2) clk_main_a0 = ~clk_main_a0;
  end

  // ----------------------------------------------------------
  // Failure reporting and helpers
  // ----------------------------------------------------------
  task automatic abort_run();
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic timeout_fail(input string what);
    $display("Timeout at %0t ns: the %s handshake never completed", $time, what);
    abort_run();
  endtask

  task automatic check_value(input string what, input data_t exp, input data_t act);
    assert (act === exp) else begin
      $display("** Error at %0t ns: %s expected %h, got %h", $time, what, exp, act);
      abort_run();
    end
  endtask

  // Idle gap or stall length of 0 to 3 cycles
  function automatic int rand_cycles();
    return {$random(seed)} % 4;
  endfunction

  // Byte 0 lands in the top byte
  function automatic data_t reverse_bytes(input data_t d);
    data_t r;
    for (int i = 0; i < 4; i++)
      r[8*(3-i) +: 8] = d[8*i +: 8];
    return r;
  endfunction

  // ----------------------------------------------------------
  // Host write with address and data offered together
  // ----------------------------------------------------------
  task automatic write_word(input addr_t addr, input data_t data);
    int n;
    int stall;
    @(posedge clk_main_a0);
    awvalid <= 1'b1;
    awaddr  <= addr;
    wvalid  <= 1'b1;
    wdata   <= data;
    wstrb   <= 4'hf;
    // Address taken at the edge after awready seen high
    n = 0;
    @(negedge clk_main_a0);
    while (!awready) begin
      n++;
      if (n > HS_TIMEOUT) timeout_fail("write address");
      @(negedge clk_main_a0);
    end
    @(posedge clk_main_a0);
    awvalid <= 1'b0;
    // Data beat accepted once the stage is busy
    n = 0;
    @(negedge clk_main_a0);
    while (!wready) begin
      n++;
      if (n > HS_TIMEOUT) timeout_fail("write data");
      @(negedge clk_main_a0);
    end
    @(posedge clk_main_a0);
    wvalid <= 1'b0;
    n = 0;
    @(negedge clk_main_a0);
    while (!bvalid) begin
      n++;
      if (n > HS_TIMEOUT) timeout_fail("write response");
      @(negedge clk_main_a0);
    end
    check_value("bresp", RESP_OKAY, bresp);
    // Response held and address blocked while bready stalls
    stall = rand_cycles();
    repeat (stall) begin
      @(negedge clk_main_a0);
      check_value("bvalid during stall", 1, bvalid);
      check_value("awready during stall", 0, awready);
    end
    // One-cycle bready pulse
    @(posedge clk_main_a0);
    bready <= 1'b1;
    @(posedge clk_main_a0);
    bready <= 1'b0;
    @(negedge clk_main_a0);
    check_value("bvalid after accept", 0, bvalid);
    check_value("awready after accept", 1, awready);
  endtask

  // ----------------------------------------------------------
  // Host read with a one-cycle arvalid
  // ----------------------------------------------------------
  task automatic read_word(input addr_t addr, input data_t model_exp, input data_t file_exp);
    int    n;
    int    stall;
    data_t held;
    n = 0;
    @(negedge clk_main_a0);
    while (!arready) begin
      n++;
      if (n > HS_TIMEOUT) timeout_fail("read address");
      @(negedge clk_main_a0);
    end
    @(posedge clk_main_a0);
    arvalid <= 1'b1;
    araddr  <= addr;
    @(posedge clk_main_a0);
    arvalid <= 1'b0;
    n = 0;
    @(negedge clk_main_a0);
    while (!rvalid) begin
      n++;
      if (n > HS_TIMEOUT) timeout_fail("read response");
      @(negedge clk_main_a0);
    end
    // Data checked against the model and the file
    check_value("rdata vs model", model_exp, rdata);
    check_value("rdata vs file", file_exp, rdata);
    check_value("rresp", RESP_OKAY, rresp);
    held  = rdata;
    stall = rand_cycles();
    repeat (stall) begin
      @(negedge clk_main_a0);
      check_value("rvalid during stall", 1, rvalid);
      check_value("rdata during stall", held, rdata);
      check_value("arready during stall", 0, arready);
    end
    // One-cycle rready pulse
    @(posedge clk_main_a0);
    rready <= 1'b1;
    @(posedge clk_main_a0);
    rready <= 1'b0;
    @(negedge clk_main_a0);
    check_value("rvalid after accept", 0, rvalid);
    check_value("arready after accept", 1, arready);
  endtask

  // DIP change and wait for the masked LEDs to settle
  task automatic apply_dip(input led_t dip, input led_t file_exp);
    int   n;
    led_t model_led;
    // LED lit where the hello low half and its switch are both set
    model_led = hello_model[15:0] & dip;
    @(posedge clk_main_a0);
    vdip <= dip;
    n = 0;
    @(negedge clk_main_a0);
    while (vled !== model_led) begin
      n++;
      if (n > LED_TIMEOUT) timeout_fail("LED settle");
      @(negedge clk_main_a0);
    end
    check_value("vled", file_exp, vled);
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    integer      fd;
    integer      code;
    string       line;
    logic [7:0]  op;
    logic [31:0] arg_a;
    logic [31:0] arg_b;
    data_t       exp;
    seed            = 32'hf034_dd07;
    hello_model     = '0;
    rst_main_n_sync = 1'b0;
    // All DUT inputs idle during reset
    awvalid = 1'b0;
    awaddr  = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    bready  = 1'b0;
    arvalid = 1'b0;
    araddr  = '0;
    rready  = 1'b0;
    vdip    = '0;
    repeat (RESET_CYCLES) @(posedge clk_main_a0);
    rst_main_n_sync <= 1'b1;
    // Idle state straight out of reset
    @(negedge clk_main_a0);
    check_value("awready at reset", 1, awready);
    check_value("arready at reset", 1, arready);
    check_value("bvalid at reset", 0, bvalid);
    check_value("rvalid at reset", 0, rvalid);
    check_value("vled at reset", 0, vled);
    fd = $fopen("tb/cl_hello_world_stim.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file");
      abort_run();
    end
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      // Skip blank lines and lines starting with a hash (8'h23)
      if (code > 0 && line.len() > 1 && line.getc(0) != 8'h23) begin
        if ($sscanf(line, "%c %h %h", op, arg_a, arg_b) != 3) begin
          $display("Malformed stimulus line: %s", line);
          abort_run();
        end
        // Random idle gap before each operation
        repeat (rand_cycles()) @(posedge clk_main_a0);
        case (op)
          "W": begin
            write_word(arg_a, arg_b);
            if (arg_a == HELLO_REG_ADDR) hello_model = arg_b;
          end
          "R": begin
            if (arg_a == HELLO_REG_ADDR)     exp = reverse_bytes(hello_model);
            else if (arg_a == VLED_REG_ADDR) exp = {16'h0000, hello_model[15:0]};
            else                             exp = UNIMPL_REG_VALUE;
            read_word(arg_a, exp, arg_b);
          end
          "D": apply_dip(arg_a[15:0], arg_b[15:0]);
          default: begin
            $display("Unknown stimulus operation: %s", line);
            abort_run();
          end
        endcase
      end
    end
    $fclose(fd);
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

/* tb/cl_hello_world_stim.txt */
# Columns: op arg_a arg_b, all hex. W addr data / R addr expected_rdata
# D dip expected_led. Reset state first, then hello writes and LED masking
R 00000500 00000000
R 00000504 00000000
R 00000700 deaddead
W 00000500 12345678
R 00000500 78563412
R 00000504 00005678
D 0000ffff 00005678
D 000000f0 00000070
W 00000500 a5c30ff1
R 00000500 f10fc3a5
R 00000504 00000ff1
D 0000ff0f 00000f01
# Writes outside the hello register leave it unchanged
W 00000504 11111111
W 00000600 22222222
R 00000500 f10fc3a5
R 00000600 deaddead
R 00000000 deaddead
R 00000508 deaddead
W 00000500 deadbeef
R 00000500 efbeadde
R 00000504 0000beef
D 0000aaaa 0000aaaa
D 00000000 00000000

/* cl_hello_world.f */
verilog/hello_pkg.sv
verilog/reg_access_if.sv
verilog/axil_wr_ctrl.sv
verilog/hello_regs.sv
verilog/axil_rd_ctrl.sv
verilog/cl_hello_world.sv
tb/cl_hello_world_tb.sv
